// ==== source/glbl_bus_pkg.sv ====
// Register bus package
// Word, address and byte-enable types of the global register bus,
// the request bundle sent to the register blocks and a byte merge helper

package glbl_bus_pkg;

   // One register word, word address and byte lanes
   typedef logic [31:0] reg_data_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [3:0]  reg_be_t;

   // Request seen by both register blocks
   // wr is the single-cycle write strobe of an accepted write
   typedef struct packed {
      logic      wr;
      reg_addr_t addr;
      reg_data_t wdata;
      reg_be_t   be;
   } reg_req_t;

   // Replace the enabled byte lanes of cur with wdata
   function automatic reg_data_t be_merge(reg_data_t cur, reg_data_t wdata, reg_be_t be);
      reg_data_t res;
      res = cur;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
      end
      return res;
   endfunction

endpackage

// ==== source/glbl_map_pkg.sv ====
// Global register map package
// Word addresses, reset defaults, identity constants, reset and strap
// bundles and interrupt source widths

package glbl_map_pkg;

   // Word addresses
   localparam glbl_bus_pkg::reg_addr_t ADDR_CHIP_ID      = 5'd0;
   localparam glbl_bus_pkg::reg_addr_t ADDR_RST_CTRL     = 5'd1;
   localparam glbl_bus_pkg::reg_addr_t ADDR_GLBL_CFG     = 5'd2;
   localparam glbl_bus_pkg::reg_addr_t ADDR_INTR_MASK    = 5'd3;
   localparam glbl_bus_pkg::reg_addr_t ADDR_INTR_STAT    = 5'd4;
   localparam glbl_bus_pkg::reg_addr_t ADDR_MFUNC_SEL    = 5'd5;
   localparam glbl_bus_pkg::reg_addr_t ADDR_INTR_SET     = 5'd10;
   localparam glbl_bus_pkg::reg_addr_t ADDR_MAILBOX      = 5'd15;
   localparam glbl_bus_pkg::reg_addr_t ADDR_SCRATCH_BASE = 5'd16;

   localparam int NUM_SCRATCH   = 8;
   localparam int SCRATCH_IDX_W = $clog2(NUM_SCRATCH);

   // Manufacturer id, core count, chip id, revision
   localparam glbl_bus_pkg::reg_data_t CHIP_ID_WORD = {16'h8268, 4'h1, 4'h6, 8'h01};

   // Reset control defaults, boot variant also releases core 0
   localparam glbl_bus_pkg::reg_data_t RST_CTRL_DEFAULT      = 32'h0000_0003;
   localparam glbl_bus_pkg::reg_data_t RST_CTRL_BOOT_DEFAULT = 32'h0000_0103;

   // UART master and RISC-V TAP enabled out of reset
   localparam glbl_bus_pkg::reg_data_t MFUNC_SEL_DEFAULT = 32'hC000_0000;

   // Scratch words 0..2 carry identification constants
   localparam glbl_bus_pkg::reg_data_t SCRATCH_SIGNATURE    = 32'h8273_8343;
   localparam glbl_bus_pkg::reg_data_t SCRATCH_RELEASE_DATE = 32'h1109_0023;
   localparam glbl_bus_pkg::reg_data_t SCRATCH_REVISION     = 32'h0005_2000;

   // Active-low block resets, cores in bits 11..8 of the register
   typedef struct packed {
      logic [3:0] core_rst_n;
      logic       cpu_intf_rst_n;
      logic       qspim_rst_n;
      logic       sspim_rst_n;
      logic [1:0] uart_rst_n;
      logic       i2cm_rst_n;
      logic       usb_rst_n;
   } periph_rst_t;

   // Pad straps used for register defaults
   typedef struct packed {
      logic riscv_boot_mode;
      logic cache_bypass;
      logic sram_clk_edge;
   } boot_strap_t;

   localparam int NUM_GPIO_INTR  = 24;
   localparam int NUM_ASYNC_INTR = 4;
   localparam int NUM_TIMER_INTR = 3;

endpackage

// ==== source/glbl_reg_bus.sv ====
// Register bus front end
// Accepts one access per cs/ack pair, issues the write strobe and
// returns registered read data with a one-cycle acknowledge

`timescale 1ns/100ps

module glbl_reg_bus (
   input  logic                    mclk,
   input  logic                    s_reset_n,
   input  logic                    reg_cs,
   input  logic                    reg_wr,
   input  glbl_bus_pkg::reg_addr_t reg_addr,
   input  glbl_bus_pkg::reg_data_t reg_wdata,
   input  glbl_bus_pkg::reg_be_t   reg_be,
   input  glbl_bus_pkg::reg_data_t cfg_rdata,
   input  glbl_bus_pkg::reg_data_t intr_rdata,
   output glbl_bus_pkg::reg_req_t  reg_req,
   output glbl_bus_pkg::reg_data_t reg_rdata,
   output logic                    reg_ack
);

   logic                    accept;
   glbl_bus_pkg::reg_data_t rd_mux;

   // ----------------------------------------------------------------------
   // Access acceptance
   // ----------------------------------------------------------------------

   // Ack cycle blocks a new accept, held cs gives one access per two cycles
   assign accept = reg_cs & ~reg_ack;

   // Request to the register blocks
   // Strobe only on the accepting cycle so every write lands once
   assign reg_req.wr    = accept & reg_wr;
   assign reg_req.addr  = reg_addr;
   assign reg_req.wdata = reg_wdata;
   assign reg_req.be    = reg_be;

   // Each block returns zero outside its own words
   assign rd_mux = cfg_rdata | intr_rdata;

   // ----------------------------------------------------------------------
   // Acknowledge and read data
   // ----------------------------------------------------------------------

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_ack <= 1'b0;
      end else begin
         reg_ack <= accept;
      end
   end

   // Read data captured with the accept, writes capture too
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         reg_rdata <= '0;
      end else if (accept) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

// ==== source/glbl_cfg_regs.sv ====
// Global configuration registers
// Chip identity, reset control, global config, pin select, mailbox and
// scratch words, with the decoded reset and config outputs

`timescale 1ns/100ps

module glbl_cfg_regs (
   input  logic                      mclk,
   input  logic                      s_reset_n,
   input  glbl_bus_pkg::reg_req_t    reg_req,
   input  glbl_map_pkg::boot_strap_t boot_strap,
   output glbl_bus_pkg::reg_data_t   cfg_rdata,
   output glbl_map_pkg::periph_rst_t periph_rst,
   output logic                      soft_irq,
   output logic [2:0]                user_irq,
   output logic                      cfg_gpio_dgmode,
   output logic [15:0]               cfg_riscv_ctrl,
   output glbl_bus_pkg::reg_data_t   cfg_multi_func_sel
);

   // Scratch reset image, words 0..2 hold the identification constants
   localparam glbl_bus_pkg::reg_data_t [glbl_map_pkg::NUM_SCRATCH-1:0] SCRATCH_INIT =
      {{(glbl_map_pkg::NUM_SCRATCH-3){32'h0}},
       glbl_map_pkg::SCRATCH_REVISION,
       glbl_map_pkg::SCRATCH_RELEASE_DATE,
       glbl_map_pkg::SCRATCH_SIGNATURE};

   glbl_bus_pkg::reg_data_t rst_ctrl_q;
   glbl_bus_pkg::reg_data_t glbl_cfg_q;
   glbl_bus_pkg::reg_data_t mfunc_sel_q;
   glbl_bus_pkg::reg_data_t mailbox_q;
   glbl_bus_pkg::reg_data_t [glbl_map_pkg::NUM_SCRATCH-1:0] scratch_q;

   glbl_bus_pkg::reg_data_t rst_ctrl_init;
   glbl_bus_pkg::reg_data_t glbl_cfg_init;
   glbl_bus_pkg::reg_addr_t scr_off;
   logic                    scr_hit;
   logic [glbl_map_pkg::SCRATCH_IDX_W-1:0] scr_idx;

   // ----------------------------------------------------------------------
   // Strap dependent reset values
   // ----------------------------------------------------------------------

   // Boot mode strap takes core 0 out of reset
   assign rst_ctrl_init = boot_strap.riscv_boot_mode ? glbl_map_pkg::RST_CTRL_BOOT_DEFAULT
                                                     : glbl_map_pkg::RST_CTRL_DEFAULT;

   // Cache bypass in 27..26, SRAM clock edge in 23..20
   assign glbl_cfg_init = {4'h0, {2{boot_strap.cache_bypass}}, 2'b00,
                           {4{boot_strap.sram_clk_edge}}, 20'h0};

   // Scratch window decode
   assign scr_off = reg_req.addr - glbl_map_pkg::ADDR_SCRATCH_BASE;
   assign scr_hit = scr_off < glbl_bus_pkg::reg_addr_t'(glbl_map_pkg::NUM_SCRATCH);
   assign scr_idx = scr_off[glbl_map_pkg::SCRATCH_IDX_W-1:0];

   // ----------------------------------------------------------------------
   // Registers, byte-enable writes
   // ----------------------------------------------------------------------

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         rst_ctrl_q  <= rst_ctrl_init;
         glbl_cfg_q  <= glbl_cfg_init;
         mfunc_sel_q <= glbl_map_pkg::MFUNC_SEL_DEFAULT;
         mailbox_q   <= '0;
         scratch_q   <= SCRATCH_INIT;
      end else if (reg_req.wr) begin
         case (reg_req.addr)
            glbl_map_pkg::ADDR_RST_CTRL:
               rst_ctrl_q <= glbl_bus_pkg::be_merge(rst_ctrl_q, reg_req.wdata, reg_req.be);
            glbl_map_pkg::ADDR_GLBL_CFG:
               glbl_cfg_q <= glbl_bus_pkg::be_merge(glbl_cfg_q, reg_req.wdata, reg_req.be);
            glbl_map_pkg::ADDR_MFUNC_SEL:
               mfunc_sel_q <= glbl_bus_pkg::be_merge(mfunc_sel_q, reg_req.wdata, reg_req.be);
            glbl_map_pkg::ADDR_MAILBOX:
               mailbox_q <= glbl_bus_pkg::be_merge(mailbox_q, reg_req.wdata, reg_req.be);
            default: begin
               // Identity word and unowned addresses fall through
               if (scr_hit) begin
                  scratch_q[scr_idx] <= glbl_bus_pkg::be_merge(scratch_q[scr_idx],
                                                               reg_req.wdata, reg_req.be);
               end
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Read mux, zero outside this block
   // ----------------------------------------------------------------------

   always_comb begin
      case (reg_req.addr)
         glbl_map_pkg::ADDR_CHIP_ID:   cfg_rdata = glbl_map_pkg::CHIP_ID_WORD;
         glbl_map_pkg::ADDR_RST_CTRL:  cfg_rdata = rst_ctrl_q;
         glbl_map_pkg::ADDR_GLBL_CFG:  cfg_rdata = glbl_cfg_q;
         glbl_map_pkg::ADDR_MFUNC_SEL: cfg_rdata = mfunc_sel_q;
         glbl_map_pkg::ADDR_MAILBOX:   cfg_rdata = mailbox_q;
         default:                      cfg_rdata = scr_hit ? scratch_q[scr_idx] : '0;
      endcase
   end

   // ----------------------------------------------------------------------
   // Decoded outputs
   // ----------------------------------------------------------------------

   // Block resets, bit 7 unused
   assign periph_rst.cpu_intf_rst_n = rst_ctrl_q[0];
   assign periph_rst.qspim_rst_n    = rst_ctrl_q[1];
   assign periph_rst.sspim_rst_n    = rst_ctrl_q[2];
   assign periph_rst.uart_rst_n     = {rst_ctrl_q[6], rst_ctrl_q[3]};
   assign periph_rst.i2cm_rst_n     = rst_ctrl_q[4];
   assign periph_rst.usb_rst_n      = rst_ctrl_q[5];
   assign periph_rst.core_rst_n     = rst_ctrl_q[11:8];

   // Config fields, monitor select in 7..4 is stored only
   assign cfg_riscv_ctrl     = glbl_cfg_q[31:16];
   assign cfg_gpio_dgmode    = glbl_cfg_q[8];
   assign soft_irq           = glbl_cfg_q[3];
   assign user_irq           = glbl_cfg_q[2:0];
   assign cfg_multi_func_sel = mfunc_sel_q;

endmodule

// ==== source/glbl_intr_ctrl.sv ====
// Global interrupt controller
// Synchronizes the asynchronous sources, keeps sticky status with
// software set and write-one clear, and masks it onto irq_lines

`timescale 1ns/100ps

module glbl_intr_ctrl (
   input  logic                                    mclk,
   input  logic                                    s_reset_n,
   input  glbl_bus_pkg::reg_req_t                  reg_req,
   input  logic                                    usb_intr,
   input  logic                                    i2cm_intr,
   input  logic                                    rtc_intr,
   input  logic                                    ir_intr,
   input  logic                                    pwm_intr,
   input  logic [glbl_map_pkg::NUM_TIMER_INTR-1:0] timer_intr,
   input  logic [glbl_map_pkg::NUM_GPIO_INTR-1:0]  gpio_intr,
   output glbl_bus_pkg::reg_data_t                 intr_rdata,
   output glbl_bus_pkg::reg_data_t                 irq_lines
);

   logic [glbl_map_pkg::NUM_ASYNC_INTR-1:0] async_in;
   logic [glbl_map_pkg::NUM_ASYNC_INTR-1:0] async_s;
   logic [glbl_map_pkg::NUM_ASYNC_INTR-1:0] async_ss;

   glbl_bus_pkg::reg_data_t hw_req;
   glbl_bus_pkg::reg_data_t wr_bytes;
   glbl_bus_pkg::reg_data_t intr_req;
   glbl_bus_pkg::reg_data_t stat_clr;
   glbl_bus_pkg::reg_data_t stat_q;
   glbl_bus_pkg::reg_data_t mask_q;
   logic                    set_wr;
   logic                    stat_wr;

   // ----------------------------------------------------------------------
   // Double synchronizers
   // ----------------------------------------------------------------------

   // Order I2C, USB, RTC, IR from bit 0
   assign async_in = {ir_intr, rtc_intr, usb_intr, i2cm_intr};

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         async_s  <= '0;
         async_ss <= '0;
      end else begin
         async_s  <= async_in;
         async_ss <= async_s;
      end
   end

   // Status bit order, GPIO on top
   assign hw_req = {gpio_intr, async_ss[3], async_ss[2], pwm_intr,
                    async_ss[1], async_ss[0], timer_intr};

   // ----------------------------------------------------------------------
   // Software set and clear
   // ----------------------------------------------------------------------

   // Byte-enabled write data, zero in disabled lanes
   assign wr_bytes = glbl_bus_pkg::be_merge('0, reg_req.wdata, reg_req.be);

   assign set_wr  = reg_req.wr && (reg_req.addr == glbl_map_pkg::ADDR_INTR_SET);
   assign stat_wr = reg_req.wr && (reg_req.addr == glbl_map_pkg::ADDR_INTR_STAT);

   assign intr_req = hw_req | (set_wr ? wr_bytes : '0);
   assign stat_clr = stat_wr ? wr_bytes : '0;

   // Sticky status, a pending request wins over a clear
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         stat_q <= '0;
      end else begin
         stat_q <= (stat_q & ~stat_clr) | intr_req;
      end
   end

   // Mask register
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         mask_q <= '0;
      end else if (reg_req.wr && (reg_req.addr == glbl_map_pkg::ADDR_INTR_MASK)) begin
         mask_q <= glbl_bus_pkg::be_merge(mask_q, reg_req.wdata, reg_req.be);
      end
   end

   // Read back, set address mirrors status
   always_comb begin
      case (reg_req.addr)
         glbl_map_pkg::ADDR_INTR_MASK: intr_rdata = mask_q;
         glbl_map_pkg::ADDR_INTR_STAT: intr_rdata = stat_q;
         glbl_map_pkg::ADDR_INTR_SET:  intr_rdata = stat_q;
         default:                      intr_rdata = '0;
      endcase
   end

   assign irq_lines = mask_q & stat_q;

endmodule

// ==== source/glbl_reg_top.sv ====
// Global register block
// Chip-select register bus front end feeding the configuration registers
// and the interrupt controller of the SoC

`timescale 1ns/100ps

module glbl_reg_top (
   input  logic                                        mclk,
   input  logic                                        s_reset_n,
   input  glbl_map_pkg::boot_strap_t                   boot_strap,
   // Register bus
   input  logic                                        reg_cs,
   input  logic                                        reg_wr,
   input  glbl_bus_pkg::reg_addr_t                     reg_addr,
   input  glbl_bus_pkg::reg_data_t                     reg_wdata,
   input  glbl_bus_pkg::reg_be_t                       reg_be,
   output glbl_bus_pkg::reg_data_t                     reg_rdata,
   output logic                                        reg_ack,
   // Hardware interrupt sources
   input  logic                                        usb_intr,
   input  logic                                        i2cm_intr,
   input  logic                                        rtc_intr,
   input  logic                                        ir_intr,
   input  logic                                        pwm_intr,
   input  logic [glbl_map_pkg::NUM_TIMER_INTR-1:0]     timer_intr,
   input  logic [glbl_map_pkg::NUM_GPIO_INTR-1:0]      gpio_intr,
   // Decoded configuration
   output glbl_map_pkg::periph_rst_t                   periph_rst,
   output logic                                        soft_irq,
   output logic [2:0]                                  user_irq,
   output logic                                        cfg_gpio_dgmode,
   output logic [15:0]                                 cfg_riscv_ctrl,
   output glbl_bus_pkg::reg_data_t                     cfg_multi_func_sel,
   output glbl_bus_pkg::reg_data_t                     irq_lines
);

   glbl_bus_pkg::reg_req_t  reg_req;
   glbl_bus_pkg::reg_data_t cfg_rdata;
   glbl_bus_pkg::reg_data_t intr_rdata;

   glbl_reg_bus u_bus (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .reg_cs     (reg_cs),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_be     (reg_be),
      .cfg_rdata  (cfg_rdata),
      .intr_rdata (intr_rdata),
      .reg_req    (reg_req),
      .reg_rdata  (reg_rdata),
      .reg_ack    (reg_ack)
   );

   glbl_cfg_regs u_cfg (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .reg_req            (reg_req),
      .boot_strap         (boot_strap),
      .cfg_rdata          (cfg_rdata),
      .periph_rst         (periph_rst),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_gpio_dgmode    (cfg_gpio_dgmode),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_multi_func_sel (cfg_multi_func_sel)
   );

   glbl_intr_ctrl u_intr (
      .mclk       (mclk),
      .s_reset_n  (s_reset_n),
      .reg_req    (reg_req),
      .usb_intr   (usb_intr),
      .i2cm_intr  (i2cm_intr),
      .rtc_intr   (rtc_intr),
      .ir_intr    (ir_intr),
      .pwm_intr   (pwm_intr),
      .timer_intr (timer_intr),
      .gpio_intr  (gpio_intr),
      .intr_rdata (intr_rdata),
      .irq_lines  (irq_lines)
   );

endmodule

// ==== dv/glbl_reg_sva.sv ====
// Global register block assertions
// Acknowledge protocol of the register bus and masking of irq_lines,
// bound onto the top level

`timescale 1ns/100ps

module glbl_reg_sva (
   input logic                    mclk,
   input logic                    s_reset_n,
   input logic                    reg_cs,
   input logic                    reg_ack,
   input glbl_bus_pkg::reg_data_t irq_lines,
   input glbl_bus_pkg::reg_data_t mask,
   input glbl_bus_pkg::reg_data_t stat
);

   // Single-cycle acknowledge
   ack_single: assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_ack |=> !reg_ack)
      else $error("reg_ack high on two cycles in a row");

   // Accepting cycle is followed by ack
   ack_follows: assert property (@(posedge mclk) disable iff (!s_reset_n)
      (reg_cs && !reg_ack) |=> reg_ack)
      else $error("accepted access without reg_ack on the next cycle");

   // No ack without an accepting cycle before it
   ack_cause: assert property (@(posedge mclk) disable iff (!s_reset_n)
      reg_ack |-> $past(reg_cs && !reg_ack))
      else $error("reg_ack without an accepting cycle");

   ack_reset: assert property (@(posedge mclk) !s_reset_n |-> !reg_ack)
      else $error("reg_ack high during reset");

   irq_mask: assert property (@(posedge mclk) disable iff (!s_reset_n)
      irq_lines == (mask & stat))
      else $error("irq_lines differs from mask and status");

endmodule

bind glbl_reg_top glbl_reg_sva i_sva (
   .mclk      (mclk),
   .s_reset_n (s_reset_n),
   .reg_cs    (reg_cs),
   .reg_ack   (reg_ack),
   .irq_lines (irq_lines),
   .mask      (u_intr.mask_q),
   .stat      (u_intr.stat_q)
);

// ==== dv/glbl_reg_chk.sv ====
// Global register block checker
// Mirrors accepted bus writes and interrupt sources into a register model,
// compares read data and decoded outputs and keeps result counts

`timescale 1ns/100ps

module glbl_reg_chk (
   input logic                      mclk,
   input logic                      s_reset_n,
   input glbl_map_pkg::boot_strap_t boot_strap,
   input logic                      reg_cs,
   input logic                      reg_wr,
   input glbl_bus_pkg::reg_addr_t   reg_addr,
   input glbl_bus_pkg::reg_data_t   reg_wdata,
   input glbl_bus_pkg::reg_be_t     reg_be,
   input glbl_bus_pkg::reg_data_t   reg_rdata,
   input logic                      reg_ack,
   input logic                      usb_intr,
   input logic                      i2cm_intr,
   input logic                      rtc_intr,
   input logic                      ir_intr,
   input logic                      pwm_intr,
   input logic [2:0]                timer_intr,
   input logic [23:0]               gpio_intr,
   input glbl_map_pkg::periph_rst_t periph_rst,
   input logic                      soft_irq,
   input logic [2:0]                user_irq,
   input logic                      cfg_gpio_dgmode,
   input logic [15:0]               cfg_riscv_ctrl,
   input glbl_bus_pkg::reg_data_t   cfg_multi_func_sel,
   input glbl_bus_pkg::reg_data_t   irq_lines
);

   glbl_bus_pkg::reg_data_t mdl [32];
   glbl_bus_pkg::reg_data_t mask_m;
   glbl_bus_pkg::reg_data_t stat_m;
   glbl_bus_pkg::reg_data_t exp_rd;
   glbl_bus_pkg::reg_data_t hw;
   glbl_bus_pkg::reg_data_t wb;
   glbl_bus_pkg::reg_data_t clr;
   glbl_bus_pkg::reg_data_t set;
   glbl_map_pkg::periph_rst_t exp_rst;
   logic [3:0] sync1;
   logic [3:0] sync2;
   logic       out_pend;
   int err_count;
   int chk_count;
   int acc_count;
   int test_err;
   int test_chk;

   function automatic glbl_bus_pkg::reg_data_t merge(glbl_bus_pkg::reg_data_t cur,
                                                     glbl_bus_pkg::reg_data_t wd,
                                                     glbl_bus_pkg::reg_be_t be);
      glbl_bus_pkg::reg_data_t res;
      res = cur;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) res[8*i +: 8] = wd[8*i +: 8];
      end
      return res;
   endfunction

   // Plain storage words of the config block
   function automatic logic is_cfg_word(int a);
      return a == 1 || a == 2 || a == 5 || a == 15 || (a >= 16 && a < 24);
   endfunction

   function automatic glbl_bus_pkg::reg_data_t exp_read(int a);
      if (a == 0) return glbl_map_pkg::CHIP_ID_WORD;
      if (a == 3) return mask_m;
      if (a == 4 || a == 10) return stat_m;
      if (is_cfg_word(a)) return mdl[a];
      return '0;
   endfunction

   task automatic mismatch(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      err_count++;
      test_err++;
   endtask

   task automatic test_done(input string name);
      $display("test %s: %0d checks, %0d errors", name, test_chk, test_err);
      test_chk = 0;
      test_err = 0;
   endtask

   task automatic summary();
      $display("total: %0d checks, %0d errors, %0d accesses", chk_count, err_count, acc_count);
   endtask

   initial begin
      err_count = 0;
      chk_count = 0;
      acc_count = 0;
      test_err  = 0;
      test_chk  = 0;
   end

   // ----------------------------------------------------------------------
   // Model update and compare, on the falling edge where ports are stable
   // ----------------------------------------------------------------------

   always @(negedge mclk) begin
      if (!s_reset_n) begin
         for (int i = 0; i < 32; i++) mdl[i] = '0;
         mdl[1] = boot_strap.riscv_boot_mode ? glbl_map_pkg::RST_CTRL_BOOT_DEFAULT
                                             : glbl_map_pkg::RST_CTRL_DEFAULT;
         // Straps at 27..26 and 23..20
         mdl[2] = (boot_strap.cache_bypass ? 32'h0C00_0000 : 32'h0) |
                  (boot_strap.sram_clk_edge ? 32'h00F0_0000 : 32'h0);
         mdl[5]  = glbl_map_pkg::MFUNC_SEL_DEFAULT;
         mdl[16] = glbl_map_pkg::SCRATCH_SIGNATURE;
         mdl[17] = glbl_map_pkg::SCRATCH_RELEASE_DATE;
         mdl[18] = glbl_map_pkg::SCRATCH_REVISION;
         mask_m   = '0;
         stat_m   = '0;
         sync1    = '0;
         sync2    = '0;
         out_pend = 1'b0;
      end else begin
         if (reg_ack) begin
            chk_count++;
            test_chk++;
            if (reg_rdata !== exp_rd)
               mismatch($sformatf("read data %h, expected %h", reg_rdata, exp_rd));
         end
         if (out_pend) begin
            exp_rst.core_rst_n     = mdl[1][11:8];
            exp_rst.cpu_intf_rst_n = mdl[1][0];
            exp_rst.qspim_rst_n    = mdl[1][1];
            exp_rst.sspim_rst_n    = mdl[1][2];
            exp_rst.uart_rst_n     = {mdl[1][6], mdl[1][3]};
            exp_rst.i2cm_rst_n     = mdl[1][4];
            exp_rst.usb_rst_n      = mdl[1][5];
            chk_count++;
            test_chk++;
            if (periph_rst !== exp_rst)
               mismatch($sformatf("periph_rst %h, expected %h", periph_rst, exp_rst));
            if ({cfg_riscv_ctrl, cfg_gpio_dgmode, soft_irq, user_irq} !==
                {mdl[2][31:16], mdl[2][8], mdl[2][3], mdl[2][2:0]})
               mismatch($sformatf("config outputs differ from word %h", mdl[2]));
            if (cfg_multi_func_sel !== mdl[5])
               mismatch($sformatf("cfg_multi_func_sel %h, expected %h",
                                  cfg_multi_func_sel, mdl[5]));
            out_pend = 1'b0;
         end
         if (irq_lines !== (mask_m & stat_m))
            mismatch($sformatf("irq_lines %h, expected %h", irq_lines, mask_m & stat_m));

         // Request as seen by status at the coming edge
         hw  = {gpio_intr, sync2[3], sync2[2], pwm_intr, sync2[1], sync2[0], timer_intr};
         clr = '0;
         set = '0;
         if (reg_cs && !reg_ack) begin
            acc_count++;
            exp_rd = exp_read(int'(reg_addr));
            if (reg_wr) begin
               wb = merge('0, reg_wdata, reg_be);
               if (reg_addr == 3) mask_m = merge(mask_m, reg_wdata, reg_be);
               else if (reg_addr == 4) clr = wb;
               else if (reg_addr == 10) set = wb;
               else if (is_cfg_word(int'(reg_addr)))
                  mdl[reg_addr] = merge(mdl[reg_addr], reg_wdata, reg_be);
               if (reg_addr == 1 || reg_addr == 2 || reg_addr == 5) out_pend = 1'b1;
            end
         end
         // Set wins over clear
         stat_m = (stat_m & ~clr) | hw | set;
         sync2  = sync1;
         sync1  = {ir_intr, rtc_intr, usb_intr, i2cm_intr};
      end
   end

endmodule

// ==== dv/glbl_reg_tb.sv ====
// Global register block testbench
// Clock, reset, random bus and interrupt stimulus, DUT and checker,
// cycle timeout

`timescale 1ns/100ps

module glbl_reg_tb;

   localparam int NUM_ACCESS  = 183;
   localparam int CYCLE_LIMIT = NUM_ACCESS * 4 + 600;

   logic mclk;
   logic s_reset_n;
   glbl_map_pkg::boot_strap_t boot_strap;
   logic reg_cs;
   logic reg_wr;
   glbl_bus_pkg::reg_addr_t reg_addr;
   glbl_bus_pkg::reg_data_t reg_wdata;
   glbl_bus_pkg::reg_be_t   reg_be;
   glbl_bus_pkg::reg_data_t reg_rdata;
   logic reg_ack;
   logic usb_intr;
   logic i2cm_intr;
   logic rtc_intr;
   logic ir_intr;
   logic pwm_intr;
   logic [2:0]  timer_intr;
   logic [23:0] gpio_intr;
   glbl_map_pkg::periph_rst_t periph_rst;
   logic        soft_irq;
   logic [2:0]  user_irq;
   logic        cfg_gpio_dgmode;
   logic [15:0] cfg_riscv_ctrl;
   glbl_bus_pkg::reg_data_t cfg_multi_func_sel;
   glbl_bus_pkg::reg_data_t irq_lines;

   logic [31:0] rng_state;
   int cycles;
   int tb_err;
   int acc_before;

   glbl_reg_top i_glbl_reg_top (.*);

   glbl_reg_chk i_chk (.*);

   always #10 mclk = ~mclk;

   // Timeout
   always @(posedge mclk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("sim failed");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // One access that leaves cs high when keep is set
   task automatic bus_access(input logic wr, input int a, input logic [31:0] d,
                             input logic [3:0] be, input logic keep);
      @(posedge mclk);
      #2;
      reg_cs    = 1'b1;
      reg_wr    = wr;
      reg_addr  = a[4:0];
      reg_wdata = d;
      reg_be    = be;
      @(negedge mclk);
      while (!reg_ack) @(negedge mclk);
      if (!keep) begin
         @(posedge mclk);
         #2;
         reg_cs = 1'b0;
         reg_wr = 1'b0;
      end
   endtask

   // Drive sources in status bit order
   task automatic drive_intr(input logic [31:0] w);
      timer_intr = w[2:0];
      i2cm_intr  = w[3];
      usb_intr   = w[4];
      pwm_intr   = w[5];
      rtc_intr   = w[6];
      ir_intr    = w[7];
      gpio_intr  = w[31:8];
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge mclk);
      #2;
   endtask

   initial begin
      mclk       = 1'b0;
      s_reset_n  = 1'b0;
      boot_strap = 3'b110;
      reg_cs     = 1'b0;
      reg_wr     = 1'b0;
      reg_addr   = '0;
      reg_wdata  = '0;
      reg_be     = '0;
      drive_intr('0);
      rng_state  = 32'h5337_afd1;
      cycles     = 0;
      tb_err     = 0;
      repeat (2) @(posedge mclk);
      #2;
      s_reset_n = 1'b1;

      // Reset defaults over the whole map
      for (int a = 0; a < 32; a++) bus_access(1'b0, a, '0, '0, 1'b0);
      i_chk.test_done("reset_defaults");

      // Random writes anywhere followed by a full readback
      for (int i = 0; i < 40; i++)
         bus_access(1'b1, int'(lcg_next() % 32), lcg_next(), 4'(lcg_next() % 16), 1'b0);
      for (int a = 0; a < 32; a++) bus_access(1'b0, a, '0, '0, 1'b0);
      i_chk.test_done("random_writes");

      // Decoded outputs follow reset control, config and pin select
      for (int i = 0; i < 12; i++)
         bus_access(1'b1, (i % 3 == 2) ? 5 : (i % 3) + 1, lcg_next(),
                    4'(lcg_next() % 16), 1'b0);
      i_chk.test_done("decoded_outputs");

      // Hardware pulses and a clear while some sources stay high
      bus_access(1'b1, 3, lcg_next(), 4'hf, 1'b0);
      for (int i = 0; i < 6; i++) begin
         bus_access(1'b1, 4, 32'hffff_ffff, 4'hf, 1'b0);
         drive_intr(lcg_next());
         wait_cycles(4);
         drive_intr('0);
         wait_cycles(4);
         bus_access(1'b0, 4, '0, '0, 1'b0);
         drive_intr(lcg_next() & lcg_next());
         wait_cycles(4);
         bus_access(1'b1, 4, 32'hffff_ffff, 4'hf, 1'b0);
         bus_access(1'b0, 4, '0, '0, 1'b0);
         drive_intr('0);
      end
      i_chk.test_done("hw_interrupts");

      // Software set by byte enable
      wait_cycles(4);
      bus_access(1'b1, 4, 32'hffff_ffff, 4'hf, 1'b0);
      for (int i = 0; i < 8; i++) begin
         bus_access(1'b1, 10, lcg_next(), 4'(lcg_next() % 16), 1'b0);
         bus_access(1'b0, 10, '0, '0, 1'b0);
         bus_access(1'b0, 4, '0, '0, 1'b0);
      end
      i_chk.test_done("soft_set");

      // Back-to-back with cs held high
      acc_before = i_chk.acc_count;
      for (int i = 0; i < 8; i++)
         bus_access(i % 2 == 0, 15 + (i % 4), lcg_next(), 4'hf, i != 7);
      for (int a = 15; a < 24; a++) bus_access(1'b0, a, '0, '0, a != 23);
      if (i_chk.acc_count - acc_before != 17) begin
         $display("back-to-back: %0d accesses seen, 17 issued", i_chk.acc_count - acc_before);
         tb_err++;
      end
      i_chk.test_done("back_to_back");

      wait_cycles(2);
      i_chk.summary();
      if (i_chk.err_count == 0 && tb_err == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
source/glbl_bus_pkg.sv
source/glbl_map_pkg.sv
source/glbl_reg_bus.sv
source/glbl_cfg_regs.sv
source/glbl_intr_ctrl.sv
source/glbl_reg_top.sv
dv/glbl_reg_sva.sv
dv/glbl_reg_chk.sv
dv/glbl_reg_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the global register block testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module glbl_reg_tb -o glbl_reg_sim
./obj_dir/glbl_reg_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "sim failed" sim.log; then
   exit 1
fi
if ! grep -q "sim passed" sim.log; then
   echo "run ended without a result"
   exit 1
fi
exit 0
